// ==== Makefile ====
TOP := odd_pipe_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== hw/branch_unit.sv ====
`include "spu_odd_macros.svh"

module branch_unit (
    input  spu_odd_pkg::odd_issue_t issue,
    output spu_odd_pkg::fw_entry_t  entry,
    output logic                    taken,
    output spu_odd_pkg::pc_t        next_pc
);
    import spu_odd_pkg::*;

    pc_t                    offset;
    pc_t                    relative_target;
    pc_t                    absolute_target;
    pc_t                    link_pc;
    logic [0:`WORD_WIDTH-1] rt_word;
    logic [0:15]            rt_half;
    logic                   is_branch;
    logic                   is_link;
    logic                   is_conditional;
    logic                   condition;

    // word offset from the sign-extended immediate
    assign offset          = {{14{issue.i16[0]}}, issue.i16, 2'b00};
    assign relative_target = (issue.pc + offset) & `LS_LIMIT_MASK;
    assign absolute_target = offset & `LS_LIMIT_MASK;
    assign link_pc         = (issue.pc + 32'd4) & `LS_LIMIT_MASK;

    // preferred slot of rt
    assign rt_word = issue.rt_data[0:`WORD_WIDTH-1];
    assign rt_half = issue.rt_data[16:31];

    always_comb
    begin
        is_branch      = 1'b1;
        is_link        = 1'b0;
        is_conditional = 1'b0;
        condition      = 1'b0;
        taken          = 1'b0;
        next_pc        = '0;
        case (issue.opcode)
            OP_BR:
            begin
                taken   = 1'b1;
                next_pc = relative_target;
            end
            OP_BRA:
            begin
                taken   = 1'b1;
                next_pc = absolute_target;
            end
            OP_BRSL:
            begin
                taken   = 1'b1;
                is_link = 1'b1;
                next_pc = relative_target;
            end
            OP_BRASL:
            begin
                taken   = 1'b1;
                is_link = 1'b1;
                next_pc = absolute_target;
            end
            OP_BRNZ:
            begin
                is_conditional = 1'b1;
                condition      = (rt_word != '0);
            end
            OP_BRZ:
            begin
                is_conditional = 1'b1;
                condition      = (rt_word == '0);
            end
            OP_BRHNZ:
            begin
                is_conditional = 1'b1;
                condition      = (rt_half != '0);
            end
            OP_BRHZ:
            begin
                is_conditional = 1'b1;
                condition      = (rt_half == '0);
            end
            default:
                is_branch = 1'b0;
        endcase

        // not taken falls through to the next word
        if (is_conditional)
        begin
            taken   = condition;
            next_pc = condition ? (relative_target & 32'hFFFF_FFFC) : link_pc;
        end
    end

    always_comb
    begin
        entry = '0;
        if (is_branch)
        begin
            entry.unit_id    = `BRANCH_UNIT_ID;
            entry.rt_address = issue.rt_address;
            entry.latency    = `BRANCH_LATENCY;
            // only the set-link forms write the return address back
            if (is_link)
            begin
                entry.write_enable                   = 1'b1;
                entry.rt_value[0:`WORD_WIDTH-1] = link_pc;
            end
        end
    end

endmodule

// ==== hw/forward_chain.sv ====
`include "spu_odd_macros.svh"

module forward_chain (
    input  logic                    clock,
    input  logic                    reset,
    input  spu_odd_pkg::fw_entry_t  stage_in,
    output spu_odd_pkg::fw_stages_t stages,
    output spu_odd_pkg::fw_entry_t  result
);
    import spu_odd_pkg::*;

    // registered stages 2 to 7, stage 1 is the unit output itself
    fw_entry_t [2:`FW_STAGES] pipe_q;

    assign stages = {stage_in, pipe_q};

    // each entry advances one stage per clock, result is the write-back point
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pipe_q <= '0;
            result <= '0;
        end
        else
        begin
            pipe_q <= {stage_in, pipe_q[2:`FW_STAGES-1]};
            result <= pipe_q[`FW_STAGES];
        end
    end

endmodule

// ==== hw/odd_pipe.sv ====
module odd_pipe (
    input  logic                    clock,
    input  logic                    reset,
    input  spu_odd_pkg::odd_issue_t issue,
    output spu_odd_pkg::fw_stages_t fw_stages,
    output spu_odd_pkg::fw_entry_t  result,
    output logic                    branch_taken,
    output spu_odd_pkg::pc_t        next_pc
);
    import spu_odd_pkg::*;

    odd_issue_t issue_q;
    fw_entry_t  permute_entry;
    fw_entry_t  branch_entry;
    fw_entry_t  stage1_entry;

    // operand register, clears to NOP so all unit outputs start at zero
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            issue_q <= '0;
        end
        else
        begin
            issue_q <= issue;
        end
    end

    permute_unit u_permute (
        .issue (issue_q),
        .entry (permute_entry)
    );

    branch_unit u_branch (
        .issue   (issue_q),
        .entry   (branch_entry),
        .taken   (branch_taken),
        .next_pc (next_pc)
    );

    // opcode sets are disjoint and idle units output zeros
    assign stage1_entry = permute_entry | branch_entry;

    forward_chain u_chain (
        .clock    (clock),
        .reset    (reset),
        .stage_in (stage1_entry),
        .stages   (fw_stages),
        .result   (result)
    );

endmodule

// ==== hw/permute_unit.sv ====
`include "spu_odd_macros.svh"

module permute_unit (
    input  spu_odd_pkg::odd_issue_t issue,
    output spu_odd_pkg::fw_entry_t  entry
);
    import spu_odd_pkg::*;

    quad_t rt_value;
    logic  is_permute;

    // bit 0 is the msb, so a value shift left moves data toward bit 0
    // amounts of 128 or more leave only zeros
    function automatic quad_t shift_left(input quad_t value, input logic [7:0] amount);
        quad_t shifted;
        shifted = value << amount;
        return shifted;
    endfunction

    // rotate by shifting a doubled copy and keeping the upper half
    function automatic quad_t rotate_left(input quad_t value, input logic [6:0] amount);
        logic [0:2*`QUAD_WIDTH-1] doubled;
        doubled = {value, value} << amount;
        return doubled[0:`QUAD_WIDTH-1];
    endfunction

    // last bit of each element, element 0 lands highest in the packed field
    // at the low end of word 0
    function automatic quad_t gather_bits(input quad_t value, input int elem_bits);
        quad_t gathered;
        int    count;
        gathered = '0;
        count = `QUAD_WIDTH / elem_bits;
        for (int j = 0; j < 16; j++)
        begin
            if (j < count)
            begin
                gathered[`WORD_WIDTH - count + j] = value[j * elem_bits + elem_bits - 1];
            end
        end
        return gathered;
    endfunction

    always_comb
    begin
        rt_value   = '0;
        is_permute = 1'b1;
        case (issue.opcode)
            // bit shifts, count 0..7
            OP_SHLQBI:
                rt_value = shift_left(issue.ra, {5'd0, issue.rb[29:31]});
            OP_SHLQBII:
                rt_value = shift_left(issue.ra, {5'd0, issue.i7[4:6]});

            // byte shifts, count 0..31 so 16 and up clears the quadword
            OP_SHLQBY:
                rt_value = shift_left(issue.ra, {issue.rb[27:31], 3'b000});
            OP_SHLQBYI:
                rt_value = shift_left(issue.ra, {issue.i7[2:6], 3'b000});
            OP_SHLQBYBI:
                rt_value = shift_left(issue.ra, {issue.rb[24:28], 3'b000});

            // bit rotates
            OP_ROTQBI:
                rt_value = rotate_left(issue.ra, {4'd0, issue.rb[29:31]});
            OP_ROTQBII:
                rt_value = rotate_left(issue.ra, {4'd0, issue.i7[4:6]});

            // byte rotates stay modulo 16
            OP_ROTQBY:
                rt_value = rotate_left(issue.ra, {issue.rb[28:31], 3'b000});
            OP_ROTQBYI:
                rt_value = rotate_left(issue.ra, {issue.i7[3:6], 3'b000});
            OP_ROTQBYBI:
                rt_value = rotate_left(issue.ra, {issue.rb[25:28], 3'b000});

            // gathers over bytes, halfwords and words
            OP_GBB:
                rt_value = gather_bits(issue.ra, 8);
            OP_GBH:
                rt_value = gather_bits(issue.ra, 16);
            OP_GB:
                rt_value = gather_bits(issue.ra, 32);

            default:
                is_permute = 1'b0;
        endcase
    end

    // all-zero entry for opcodes owned by other units
    always_comb
    begin
        entry = '0;
        if (is_permute)
        begin
            entry.unit_id      = `PERMUTE_UNIT_ID;
            entry.rt_value     = rt_value;
            entry.write_enable = 1'b1;
            entry.rt_address   = issue.rt_address;
            entry.latency      = `PERMUTE_LATENCY;
        end
    end

endmodule

// ==== hw/spu_odd_macros.svh ====
`ifndef SPU_ODD_MACROS_SVH
`define SPU_ODD_MACROS_SVH

// datapath widths fixed by the instruction set
`define QUAD_WIDTH 128
`define WORD_WIDTH 32
`define ADDR_WIDTH 7
`define PC_WIDTH 32

// unit ids carried in every forward entry
`define PERMUTE_UNIT_ID 3'd5
`define BRANCH_UNIT_ID 3'd7

// result latency in cycles, per unit
`define PERMUTE_LATENCY 4'd4
`define BRANCH_LATENCY 4'd1

// registered forward stages between issue and write-back
`define FW_STAGES 7

// 256 KB local store
`define LS_LIMIT_MASK 32'h0003_FFFF

`endif

// ==== hw/spu_odd_pkg.sv ====
`include "spu_odd_macros.svh"

package spu_odd_pkg;

    // bit 0 is the most significant bit in every vector below
    typedef logic [0:`QUAD_WIDTH-1] quad_t;
    typedef logic [0:`ADDR_WIDTH-1] reg_addr_t;
    typedef logic [0:`PC_WIDTH-1]   pc_t;
    typedef logic [0:2]             unit_id_t;
    typedef logic [0:3]             latency_t;
    typedef logic [0:6]             imm7_t;
    typedef logic [0:15]            imm16_t;

    // odd pipe operations, NOP doubles as the idle code
    typedef enum logic [0:4] {
        OP_NOP      = 5'd0,
        // permute: quadword left shifts
        OP_SHLQBI   = 5'd1,
        OP_SHLQBII  = 5'd2,
        OP_SHLQBY   = 5'd3,
        OP_SHLQBYI  = 5'd4,
        OP_SHLQBYBI = 5'd5,
        // permute: quadword rotates
        OP_ROTQBI   = 5'd6,
        OP_ROTQBII  = 5'd7,
        OP_ROTQBY   = 5'd8,
        OP_ROTQBYI  = 5'd9,
        OP_ROTQBYBI = 5'd10,
        // permute: gather bits
        OP_GBB      = 5'd11,
        OP_GBH      = 5'd12,
        OP_GB       = 5'd13,
        // branches
        OP_BR       = 5'd14,
        OP_BRA      = 5'd15,
        OP_BRSL     = 5'd16,
        OP_BRASL    = 5'd17,
        OP_BRNZ     = 5'd18,
        OP_BRZ      = 5'd19,
        OP_BRHNZ    = 5'd20,
        OP_BRHZ     = 5'd21
    } odd_opcode_t;

    // one issued instruction with its operands already read
    typedef struct packed {
        odd_opcode_t opcode;
        quad_t       ra;
        quad_t       rb;
        quad_t       rt_data;
        reg_addr_t   rt_address;
        imm7_t       i7;
        imm16_t      i16;
        pc_t         pc;
    } odd_issue_t;

    // 143 bits, same field order as the register file write port
    typedef struct packed {
        unit_id_t  unit_id;
        quad_t     rt_value;
        logic      write_enable;
        reg_addr_t rt_address;
        latency_t  latency;
    } fw_entry_t;

    typedef fw_entry_t [1:`FW_STAGES] fw_stages_t;

endpackage

// ==== verification/odd_pipe_model.svh ====
`ifndef ODD_PIPE_MODEL_SVH
`define ODD_PIPE_MODEL_SVH

// left shift by a bit count, bit 0 is the msb so data moves toward bit 0
function automatic quad_t quad_shifted(input quad_t value, input int bits);
    quad_t shifted;
    shifted = '0;
    for (int i = 0; i + bits < `QUAD_WIDTH; i++)
    begin
        shifted[i] = value[i + bits];
    end
    return shifted;
endfunction

// bits leaving at bit 0 come back in at bit 127
function automatic quad_t quad_rotated(input quad_t value, input int bits);
    quad_t rotated;
    for (int i = 0; i < `QUAD_WIDTH; i++)
    begin
        rotated[i] = value[(i + bits) % `QUAD_WIDTH];
    end
    return rotated;
endfunction

// shifting in one element at a time leaves element 0 most significant
function automatic quad_t bits_gathered(input quad_t value, input int elem_bits);
    quad_t       gathered;
    logic [15:0] field;
    gathered = '0;
    field    = '0;
    for (int e = 0; e < `QUAD_WIDTH / elem_bits; e++)
    begin
        field = {field[14:0], value[(e + 1) * elem_bits - 1]};
    end
    gathered[16:31] = field;
    return gathered;
endfunction

function automatic quad_t permuted_value(input odd_issue_t op);
    quad_t value;
    value = '0;
    case (op.opcode)
        OP_SHLQBI:   value = quad_shifted(op.ra, int'(op.rb[29:31]));
        OP_SHLQBII:  value = quad_shifted(op.ra, int'(op.i7[4:6]));
        OP_SHLQBY:   value = quad_shifted(op.ra, 8 * int'(op.rb[27:31]));
        OP_SHLQBYI:  value = quad_shifted(op.ra, 8 * int'(op.i7[2:6]));
        OP_SHLQBYBI: value = quad_shifted(op.ra, 8 * int'(op.rb[24:28]));
        OP_ROTQBI:   value = quad_rotated(op.ra, int'(op.rb[29:31]));
        OP_ROTQBII:  value = quad_rotated(op.ra, int'(op.i7[4:6]));
        OP_ROTQBY:   value = quad_rotated(op.ra, 8 * int'(op.rb[28:31]));
        OP_ROTQBYI:  value = quad_rotated(op.ra, 8 * int'(op.i7[3:6]));
        OP_ROTQBYBI: value = quad_rotated(op.ra, 8 * int'(op.rb[25:28]));
        OP_GBB:      value = bits_gathered(op.ra, 8);
        OP_GBH:      value = bits_gathered(op.ra, 16);
        OP_GB:       value = bits_gathered(op.ra, 32);
        default:     value = '0;
    endcase
    return value;
endfunction

function automatic pc_t link_address(input pc_t pc);
    return (pc + 32'd4) & `LS_LIMIT_MASK;
endfunction

// signed word offset, in bytes
function automatic pc_t branch_offset(input imm16_t imm);
    pc_t offset;
    offset = {{16{imm[0]}}, imm};
    return offset << 2;
endfunction

function automatic pc_t pc_relative(input odd_issue_t op);
    return (op.pc + branch_offset(op.i16)) & `LS_LIMIT_MASK;
endfunction

function automatic logic is_taken(input odd_issue_t op);
    case (op.opcode)
        OP_BR, OP_BRA, OP_BRSL, OP_BRASL:
            return 1'b1;
        OP_BRNZ:  return op.rt_data[0:31] != 32'd0;
        OP_BRZ:   return op.rt_data[0:31] == 32'd0;
        OP_BRHNZ: return op.rt_data[16:31] != 16'd0;
        OP_BRHZ:  return op.rt_data[16:31] == 16'd0;
        default:  return 1'b0;
    endcase
endfunction

function automatic pc_t target_pc(input odd_issue_t op);
    case (op.opcode)
        OP_BR, OP_BRSL:
            return pc_relative(op);
        OP_BRA, OP_BRASL:
            return branch_offset(op.i16) & `LS_LIMIT_MASK;
        OP_BRNZ, OP_BRZ, OP_BRHNZ, OP_BRHZ:
            return is_taken(op) ? (pc_relative(op) & 32'hFFFF_FFFC) : link_address(op.pc);
        default:
            return '0;
    endcase
endfunction

function automatic fw_entry_t expected_entry(input odd_issue_t op);
    fw_entry_t entry;
    entry = '0;
    case (op.opcode)
        OP_SHLQBI, OP_SHLQBII, OP_SHLQBY, OP_SHLQBYI, OP_SHLQBYBI,
        OP_ROTQBI, OP_ROTQBII, OP_ROTQBY, OP_ROTQBYI, OP_ROTQBYBI,
        OP_GBB, OP_GBH, OP_GB:
        begin
            entry.unit_id      = `PERMUTE_UNIT_ID;
            entry.rt_value     = permuted_value(op);
            entry.write_enable = 1'b1;
            entry.rt_address   = op.rt_address;
            entry.latency      = `PERMUTE_LATENCY;
        end
        OP_BR, OP_BRA, OP_BRSL, OP_BRASL, OP_BRNZ, OP_BRZ, OP_BRHNZ, OP_BRHZ:
        begin
            entry.unit_id    = `BRANCH_UNIT_ID;
            entry.rt_address = op.rt_address;
            entry.latency    = `BRANCH_LATENCY;
            // return address goes to word 0 of rt
            if (op.opcode == OP_BRSL || op.opcode == OP_BRASL)
            begin
                entry.write_enable   = 1'b1;
                entry.rt_value[0:31] = link_address(op.pc);
            end
        end
        default:
            entry = '0;
    endcase
    return entry;
endfunction

`endif

// ==== verification/odd_pipe_tb.sv ====
`include "spu_odd_macros.svh"

module odd_pipe_tb;
    import spu_odd_pkg::*;

    localparam int NUM_ISSUES     = 2000;
    localparam int RESET_CYCLES   = 10;
    localparam int DRAIN_ISSUES   = `FW_STAGES + 1;
    localparam int TIMEOUT_CYCLES = NUM_ISSUES + RESET_CYCLES + 20;
    localparam int CHECK_BITS     = 160;

    logic       clock;
    logic       reset;
    odd_issue_t issue;
    fw_stages_t fw_stages;
    fw_entry_t  result;
    logic       branch_taken;
    pc_t        next_pc;

    int         cycle_count = 0;
    // newest expected entry first, eight deep
    fw_entry_t  history[$];

    `include "odd_pipe_model.svh"

    odd_pipe dut (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue),
        .fw_stages    (fw_stages),
        .result       (result),
        .branch_taken (branch_taken),
        .next_pc      (next_pc)
    );

    always #50 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [CHECK_BITS-1:0] actual,
                         input logic [CHECK_BITS-1:0] expected);
        if (actual !== expected)
        begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // stage k holds the entry from k-1 issues back, result the one from seven back
    task automatic check_pipeline(input logic expected_taken, input pc_t expected_pc);
        string name;
        check("branch_taken", CHECK_BITS'(branch_taken), CHECK_BITS'(expected_taken));
        check("next_pc", CHECK_BITS'(next_pc), CHECK_BITS'(expected_pc));
        for (int k = 1; k <= `FW_STAGES; k++)
        begin
            name = $sformatf("fw_stages[%0d]", k);
            check(name, CHECK_BITS'(fw_stages[k]), CHECK_BITS'(history[k - 1]));
        end
        check("result", CHECK_BITS'(result), CHECK_BITS'(history[`FW_STAGES]));
    endtask

    function automatic quad_t random_quad();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic odd_issue_t random_issue();
        odd_issue_t  pick;
        logic [31:0] word;
        pick.opcode  = odd_opcode_t'($urandom_range(int'(OP_BRHZ), int'(OP_NOP)));
        pick.ra      = random_quad();
        pick.rb      = random_quad();
        pick.rt_data = random_quad();
        // zero rt often enough to take both sides of the zero tests
        if ($urandom_range(3, 0) == 0)
        begin
            pick.rt_data = '0;
        end
        word            = $urandom();
        pick.rt_address = word[6:0];
        word            = $urandom();
        pick.i7         = word[6:0];
        word            = $urandom();
        pick.i16        = word[15:0];
        pick.pc         = $urandom();
        return pick;
    endfunction

    initial
    begin
        odd_issue_t  next_issue;
        fw_entry_t   zero_entry;
        logic        want_taken;
        pc_t         want_pc;

        void'($urandom(28));
        clock      = 1'b0;
        reset      = 1'b1;
        issue      = '0;
        zero_entry = '0;
        for (int k = 0; k <= `FW_STAGES; k++)
        begin
            history.push_back(zero_entry);
        end

        // live issues during reset must not reach any output
        for (int r = 0; r < RESET_CYCLES; r++)
        begin
            @(negedge clock);
            check_pipeline(1'b0, '0);
            if (r < RESET_CYCLES - 1)
                issue = random_issue();
        end
        reset = 1'b0;

        // random issues, then NOPs until the last one reaches result
        for (int n = 0; n < NUM_ISSUES + DRAIN_ISSUES; n++)
        begin
            if (n < NUM_ISSUES)
                next_issue = random_issue();
            else
                next_issue = '0;
            issue = next_issue;
            history.push_front(expected_entry(next_issue));
            void'(history.pop_back());
            want_taken = is_taken(next_issue);
            want_pc    = target_pc(next_issue);
            @(negedge clock);
            check_pipeline(want_taken, want_pc);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
+incdir+verification
hw/spu_odd_pkg.sv
hw/permute_unit.sv
hw/branch_unit.sv
hw/forward_chain.sv
hw/odd_pipe.sv
verification/odd_pipe_tb.sv
